// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path word, also the APB address and data width.
`define CPU_REG_WIDTH 32

// Register number, 32 architectural registers.
`define CPU_REGNO_WIDTH 5

// Signed immediate carried by the issue port.
`define CPU_IMM_WIDTH 16

`endif

// File: common/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    OP_ADD,                                   // rd = rs + rt.
    OP_SUB,                                   // rd = rs - rt.
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,                                   // Signed compare, result 0 or 1.
    OP_ADDI,                                  // rd = rs + sext(imm).
    OP_LW,                                    // rd = mem[rs + sext(imm)].
    OP_SW                                     // mem[rs + sext(imm)] = rt.
  } op_t;

  typedef struct packed {
    op_t                         op;
    logic [`CPU_REGNO_WIDTH-1:0] rd_no;
    logic [`CPU_REGNO_WIDTH-1:0] rs_no;
    logic [`CPU_REGNO_WIDTH-1:0] rt_no;
    logic [`CPU_IMM_WIDTH-1:0]   imm;
  } issue_op_t;

  // Execute slot, the issued operation with its operands.
  typedef struct packed {
    op_t                         op;
    logic [`CPU_REGNO_WIDTH-1:0] rd_no;
    logic [`CPU_REGNO_WIDTH-1:0] rs_no;
    logic [`CPU_REGNO_WIDTH-1:0] rt_no;
    logic [`CPU_IMM_WIDTH-1:0]   imm;
    logic [`CPU_REG_WIDTH-1:0]   rs_val;
    logic [`CPU_REG_WIDTH-1:0]   rt_val;
  } ex_op_t;

  typedef struct packed {
    logic [`CPU_REG_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`CPU_REG_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`CPU_REG_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // Register write, rd_no of zero means no write.
  typedef struct packed {
    logic [`CPU_REGNO_WIDTH-1:0] rd_no;
    logic [`CPU_REG_WIDTH-1:0]   rd_val;
  } wb_t;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_SETUP,
    MS_ACCESS
  } mem_state_t;

endpackage

`default_nettype wire

// File: design/alu_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module alu_unit (
  input  wire cpu_pkg::ex_op_t      i_ex,
  output logic [`CPU_REG_WIDTH-1:0] o_result
);

  logic [`CPU_REG_WIDTH-1:0] imm_ext;
  logic                      lt;

  // Sign-extended immediate, also the load/store offset.
  assign imm_ext = {{(`CPU_REG_WIDTH-`CPU_IMM_WIDTH){i_ex.imm[`CPU_IMM_WIDTH-1]}}, i_ex.imm};
  assign lt      = $signed(i_ex.rs_val) < $signed(i_ex.rt_val);

  always_comb
  begin
    case (i_ex.op)
      cpu_pkg::OP_ADD:  o_result = i_ex.rs_val + i_ex.rt_val;
      cpu_pkg::OP_SUB:  o_result = i_ex.rs_val - i_ex.rt_val;
      cpu_pkg::OP_AND:  o_result = i_ex.rs_val & i_ex.rt_val;
      cpu_pkg::OP_OR:   o_result = i_ex.rs_val | i_ex.rt_val;
      cpu_pkg::OP_XOR:  o_result = i_ex.rs_val ^ i_ex.rt_val;
      cpu_pkg::OP_SLT:  o_result = {{(`CPU_REG_WIDTH-1){1'b0}}, lt};
      cpu_pkg::OP_ADDI,
      cpu_pkg::OP_LW,
      cpu_pkg::OP_SW:   o_result = i_ex.rs_val + imm_ext;   // Effective address for memory ops.
      default:          o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/cpu_backend.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_backend (
  input  wire                      clk,
  input  wire                      nrst,
  input  wire cpu_pkg::issue_op_t  i_op,
  input  wire                      i_op_valid,
  output logic                     o_op_ready,
  input  wire                      i_nullify,
  output cpu_pkg::apb_req_t        o_apb,
  input  wire cpu_pkg::apb_rsp_t   i_apb,
  output cpu_pkg::wb_t             o_wb
);

  wire [`CPU_REGNO_WIDTH-1:0] rs_no;                  // Read addresses from issue.
  wire [`CPU_REGNO_WIDTH-1:0] rt_no;
  wire [`CPU_REG_WIDTH-1:0]   rs_val;
  wire [`CPU_REG_WIDTH-1:0]   rt_val;
  wire cpu_pkg::ex_op_t       ex;                     // Execute slot.
  wire                        ex_valid;
  wire [`CPU_REG_WIDTH-1:0]   alu_val;                // ALU result or effective address.
  wire [`CPU_REG_WIDTH-1:0]   load_val;
  wire                        stall;

  regfile u_regfile (
    .clk      (clk),
    .nrst     (nrst),
    .i_rs_no  (rs_no),
    .i_rt_no  (rt_no),
    .o_rs_val (rs_val),
    .o_rt_val (rt_val),
    .i_wb     (o_wb)
  );

  issue_ctl u_issue_ctl (
    .clk        (clk),
    .nrst       (nrst),
    .i_op       (i_op),
    .i_op_valid (i_op_valid),
    .o_op_ready (o_op_ready),
    .o_rs_no    (rs_no),
    .o_rt_no    (rt_no),
    .i_rs_val   (rs_val),
    .i_rt_val   (rt_val),
    .i_stall    (stall),
    .i_wb_rd_no (o_wb.rd_no),
    .o_ex       (ex),
    .o_ex_valid (ex_valid)
  );

  alu_unit u_alu_unit (
    .i_ex     (ex),
    .o_result (alu_val)
  );

  mem_access u_mem_access (
    .clk        (clk),
    .nrst       (nrst),
    .i_ex       (ex),
    .i_ex_valid (ex_valid),
    .i_addr     (alu_val),
    .i_nullify  (i_nullify),
    .o_apb      (o_apb),
    .i_apb      (i_apb),
    .o_load_val (load_val),
    .o_stall    (stall)
  );

  writeback u_writeback (
    .clk        (clk),
    .nrst       (nrst),
    .i_stall    (stall),
    .i_nullify  (i_nullify),
    .i_ex       (ex),
    .i_ex_valid (ex_valid),
    .i_alu_val  (alu_val),
    .i_load_val (load_val),
    .o_wb       (o_wb)
  );

endmodule

`default_nettype wire

// File: design/issue_ctl.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module issue_ctl (
  input  wire                         clk,
  input  wire                         nrst,
  input  wire cpu_pkg::issue_op_t     i_op,
  input  wire                         i_op_valid,
  output logic                        o_op_ready,
  output logic [`CPU_REGNO_WIDTH-1:0] o_rs_no,
  output logic [`CPU_REGNO_WIDTH-1:0] o_rt_no,
  input  wire [`CPU_REG_WIDTH-1:0]    i_rs_val,
  input  wire [`CPU_REG_WIDTH-1:0]    i_rt_val,
  input  wire                         i_stall,
  input  wire [`CPU_REGNO_WIDTH-1:0]  i_wb_rd_no,
  output cpu_pkg::ex_op_t             o_ex,
  output logic                        o_ex_valid
);

  logic ex_writes;                                    // Slot holds a pending register write.
  logic uses_rt;                                      // Offered op reads rt.
  logic hazard_rs;
  logic hazard_rt;
  logic accept;

  assign o_rs_no = i_op.rs_no;                        // Register file read addresses.
  assign o_rt_no = i_op.rt_no;

  always_comb
  begin
    ex_writes = o_ex_valid && (o_ex.op != cpu_pkg::OP_SW);
    uses_rt   = (i_op.op != cpu_pkg::OP_ADDI) && (i_op.op != cpu_pkg::OP_LW);
    // Operand is still in flight in the slot or in writeback.
    hazard_rs = (i_op.rs_no != '0) &&
                ((ex_writes && (i_op.rs_no == o_ex.rd_no)) || (i_op.rs_no == i_wb_rd_no));
    hazard_rt = uses_rt && (i_op.rt_no != '0) &&
                ((ex_writes && (i_op.rt_no == o_ex.rd_no)) || (i_op.rt_no == i_wb_rd_no));
  end

  assign o_op_ready = !i_stall && !hazard_rs && !hazard_rt;
  assign accept     = i_op_valid && o_op_ready;

  // Execute slot, frozen while the memory unit stalls.
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_ex_valid <= 1'b0;
      o_ex       <= '0;
    end
    else if (accept)
    begin
      o_ex_valid   <= 1'b1;
      o_ex.op      <= i_op.op;
      o_ex.rd_no   <= i_op.rd_no;
      o_ex.rs_no   <= i_op.rs_no;
      o_ex.rt_no   <= i_op.rt_no;
      o_ex.imm     <= i_op.imm;
      o_ex.rs_val  <= i_rs_val;                       // Operands sampled at issue.
      o_ex.rt_val  <= i_rt_val;
    end
    else if (!i_stall)
    begin
      o_ex_valid <= 1'b0;                             // Slot drains.
    end
  end

  // The memory unit's stall must hold the same operation in the slot.
  a_slot_frozen: assert property (@(posedge clk) disable iff (!nrst)
    i_stall |=> (o_ex_valid && $stable(o_ex)));

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module regfile (
  input  wire                         clk,
  input  wire                         nrst,
  input  wire [`CPU_REGNO_WIDTH-1:0]  i_rs_no,
  input  wire [`CPU_REGNO_WIDTH-1:0]  i_rt_no,
  output logic [`CPU_REG_WIDTH-1:0]   o_rs_val,
  output logic [`CPU_REG_WIDTH-1:0]   o_rt_val,
  input  wire cpu_pkg::wb_t           i_wb
);

  logic [`CPU_REG_WIDTH-1:0] regs [1:(1<<`CPU_REGNO_WIDTH)-1];  // No storage for r0.

  // Single write port, driven by the writeback register.
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      for (int i = 1; i < (1 << `CPU_REGNO_WIDTH); i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (i_wb.rd_no != '0)
    begin
      regs[i_wb.rd_no] <= i_wb.rd_val;                // Writes to r0 dropped.
    end
  end

  // Read ports are combinational, r0 is hardwired.
  always_comb
  begin
    o_rs_val = (i_rs_no == '0) ? '0 : regs[i_rs_no];
    o_rt_val = (i_rt_no == '0) ? '0 : regs[i_rt_no];
  end

endmodule

`default_nettype wire

// File: design/writeback.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module writeback (
  input  wire                      clk,
  input  wire                      nrst,
  input  wire                      i_stall,
  input  wire                      i_nullify,
  input  wire cpu_pkg::ex_op_t     i_ex,
  input  wire                      i_ex_valid,
  input  wire [`CPU_REG_WIDTH-1:0] i_alu_val,
  input  wire [`CPU_REG_WIDTH-1:0] i_load_val,
  output cpu_pkg::wb_t             o_wb
);

  logic                        writes;
  logic [`CPU_REGNO_WIDTH-1:0] rd_no;
  logic [`CPU_REG_WIDTH-1:0]   rd_val;

  // Stores and empty or killed slots leave the register file alone.
  assign writes = i_ex_valid && (i_ex.op != cpu_pkg::OP_SW) && !i_nullify;
  assign rd_no  = writes ? i_ex.rd_no : '0;
  assign rd_val = (i_ex.op == cpu_pkg::OP_LW) ? i_load_val : i_alu_val;

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_wb <= '0;
    end
    else if (!i_stall)
    begin
      o_wb.rd_no  <= rd_no;
      o_wb.rd_val <= rd_val;                          // Holds last value while stalled.
    end
  end

endmodule

`default_nettype wire

// File: mem_access/mem_access.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module mem_access (
  input  wire                       clk,
  input  wire                       nrst,
  input  wire cpu_pkg::ex_op_t      i_ex,
  input  wire                       i_ex_valid,
  input  wire [`CPU_REG_WIDTH-1:0]  i_addr,
  input  wire                       i_nullify,
  output cpu_pkg::apb_req_t         o_apb,
  input  wire cpu_pkg::apb_rsp_t    i_apb,
  output logic [`CPU_REG_WIDTH-1:0] o_load_val,
  output logic                      o_stall
);

  cpu_pkg::mem_state_t state;
  logic                is_mem;
  logic                start;

  assign is_mem = (i_ex.op == cpu_pkg::OP_LW) || (i_ex.op == cpu_pkg::OP_SW);
  assign start  = (state == cpu_pkg::MS_IDLE) && i_ex_valid && is_mem && !i_nullify;

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state <= cpu_pkg::MS_IDLE;
    end
    else
    begin
      case (state)
        cpu_pkg::MS_IDLE:
        begin
          if (start)
          begin
            state <= cpu_pkg::MS_SETUP;
          end
        end
        cpu_pkg::MS_SETUP:  state <= cpu_pkg::MS_ACCESS;   // Always one cycle.
        cpu_pkg::MS_ACCESS:
        begin
          if (i_apb.pready)
          begin
            state <= cpu_pkg::MS_IDLE;
          end
        end
        default:            state <= cpu_pkg::MS_IDLE;
      endcase
    end
  end

  // Request comes from the frozen slot, so it is stable through ACCESS.
  always_comb
  begin
    o_apb.psel    = (state != cpu_pkg::MS_IDLE);
    o_apb.penable = (state == cpu_pkg::MS_ACCESS);
    o_apb.paddr   = o_apb.psel ? i_addr : '0;
    o_apb.pwrite  = o_apb.psel && (i_ex.op == cpu_pkg::OP_SW);
    o_apb.pwdata  = o_apb.pwrite ? i_ex.rt_val : '0;          // Store data is rt.
  end

  // Hold the pipe from the first slot cycle until the completing ACCESS.
  assign o_stall = start || (state == cpu_pkg::MS_SETUP) ||
                   ((state == cpu_pkg::MS_ACCESS) && !i_apb.pready);

  assign o_load_val = i_apb.prdata;                   // Captured by writeback on pready.

  // ACCESS keeps psel and the address, direction and data of the cycle before.
  a_penable_psel: assert property (@(posedge clk) disable iff (!nrst)
    o_apb.penable |-> (o_apb.psel && $stable(o_apb.paddr) && $stable(o_apb.pwrite) &&
                       $stable(o_apb.pwdata)));

  a_access_stable: assert property (@(posedge clk) disable iff (!nrst)
    (o_apb.penable && !i_apb.pready) |=> (o_apb.penable && $stable(o_apb)));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu_backend \
  -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

// File: verif/apb_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module apb_mem_model (
  input  wire                     clk,
  input  wire                     nrst,
  input  wire cpu_pkg::apb_req_t  i_apb,
  output cpu_pkg::apb_rsp_t       o_apb
);

  logic [`CPU_REG_WIDTH-1:0] mem [0:63];              // 64 words, byte address bits 7:2.
  logic [31:0]               lfsr_state;
  logic [1:0]                waits;
  logic [1:0]                w;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          k;
    r = '0;
    for (k = 0; k < n; k++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  initial
  begin
    lfsr_state = 32'h5bf19aa6;
    for (int i = 0; i < 64; i++)
    begin
      mem[i] = 32'h1f3d5b79 ^ (i * 32'h01000193);     // Fill depends on every address bit.
    end
  end

  assign o_apb.pslverr = 1'b0;

  always @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_apb.pready <= 1'b0;
      o_apb.prdata <= '0;
      waits        <= '0;
    end
    else if (i_apb.psel && !i_apb.penable)
    begin
      w             = 2'(take_bits(2));               // 0 to 3 wait states.
      waits        <= w;
      o_apb.pready <= (w == 2'd0);
      o_apb.prdata <= mem[i_apb.paddr[7:2]];
    end
    else if (i_apb.psel && i_apb.penable)
    begin
      if (o_apb.pready)
      begin
        if (i_apb.pwrite)
        begin
          mem[i_apb.paddr[7:2]] <= i_apb.pwdata;      // Write lands as the transfer ends.
        end
        o_apb.pready <= 1'b0;
      end
      else if (waits <= 2'd1)
      begin
        o_apb.pready <= 1'b1;
        waits        <= '0;
      end
      else
      begin
        waits <= waits - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_cpu_backend.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu_backend;

  logic               clk;
  logic               nrst;
  cpu_pkg::issue_op_t i_op;
  logic               i_op_valid;
  logic               i_nullify;
  logic               o_op_ready;
  cpu_pkg::apb_req_t  o_apb;
  cpu_pkg::apb_rsp_t  apb_rsp;
  cpu_pkg::wb_t       o_wb;

  logic [31:0]        mregs [0:31];                   // Mirror register file.
  logic [31:0]        mmem [0:63];                    // Mirror data memory.
  cpu_pkg::wb_t       exp_q [$];
  int                 acc_q [$];                      // Acceptance cycle per expected write.
  logic               alu_q [$];
  logic [31:0]        lfsr_state;
  int                 cycles;
  int                 issued;
  int                 errors;
  int                 checks;
  logic               pend_nul;                       // Nullify for the op now entering the slot.
  logic               mem_seen;
  logic [4:0]         last_rd;
  cpu_pkg::wb_t       last_wb;
  cpu_pkg::wb_t       p_wb;
  cpu_pkg::apb_req_t  p_req;
  logic               p_rdy;
  logic               p_valid;

  cpu_backend dut (
    .clk        (clk),
    .nrst       (nrst),
    .i_op       (i_op),
    .i_op_valid (i_op_valid),
    .o_op_ready (o_op_ready),
    .i_nullify  (i_nullify),
    .o_apb      (o_apb),
    .i_apb      (apb_rsp),
    .o_wb       (o_wb)
  );

  apb_mem_model u_mem (
    .clk   (clk),
    .nrst  (nrst),
    .i_apb (o_apb),
    .o_apb (apb_rsp)
  );

  always #20 clk = ~clk;                              // 40 ns period.

  // Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          k;
    r = '0;
    for (k = 0; k < n; k++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  // Reference model, applies one op to the mirrors and gives the expected write.
  function automatic cpu_pkg::wb_t predict(input cpu_pkg::issue_op_t op, input logic nul);
    cpu_pkg::wb_t r;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  ea;
    logic [31:0]  v;
    r  = '0;
    a  = mregs[op.rs_no];
    b  = mregs[op.rt_no];
    ea = a + {{16{op.imm[15]}}, op.imm};
    if (nul)
    begin
      return r;                                       // Killed op changes nothing.
    end
    case (op.op)
      cpu_pkg::OP_ADD:  v = a + b;
      cpu_pkg::OP_SUB:  v = a - b;
      cpu_pkg::OP_AND:  v = a & b;
      cpu_pkg::OP_OR:   v = a | b;
      cpu_pkg::OP_XOR:  v = a ^ b;
      cpu_pkg::OP_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::OP_ADDI: v = ea;
      cpu_pkg::OP_LW:   v = mmem[ea[7:2]];
      default:
      begin
        mmem[ea[7:2]] = b;                            // Store.
        return r;
      end
    endcase
    if (op.rd_no != 5'd0)
    begin
      mregs[op.rd_no] = v;
      r.rd_no         = op.rd_no;
      r.rd_val        = v;
    end
    return r;
  endfunction

  // Destination in 1..8, never the same as the last one written.
  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = 5'(take_bits(3)) + 5'd1;
    if (r == last_rd)
    begin
      r = (r % 5'd8) + 5'd1;
    end
    return r;
  endfunction

  task automatic send(input cpu_pkg::op_t opc, input logic [4:0] rd, input logic [4:0] rs,
                      input logic [4:0] rt, input logic [15:0] imm, input logic nul,
                      output int stalls);
    cpu_pkg::issue_op_t op;
    cpu_pkg::wb_t       exp;
    op.op    = opc;
    op.rd_no = rd;
    op.rs_no = rs;
    op.rt_no = rt;
    op.imm   = imm;
    stalls   = 0;
    @(negedge clk);
    issued++;
    i_nullify  = pend_nul;                            // Previous op is in its first slot cycle.
    pend_nul   = 1'b0;
    i_op       = op;
    i_op_valid = 1'b1;
    #1;
    while (!o_op_ready)
    begin
      stalls++;
      @(negedge clk);
      i_nullify = 1'b0;
      #1;
    end
    @(posedge clk);                                   // Accepted here.
    exp = predict(op, nul);
    if (exp.rd_no != 5'd0)
    begin
      exp_q.push_back(exp);
      acc_q.push_back(cycles);
      alu_q.push_back(opc != cpu_pkg::OP_LW);
      last_rd = exp.rd_no;
    end
    if (!nul && (opc == cpu_pkg::OP_LW || opc == cpu_pkg::OP_SW))
    begin
      mem_seen = 1'b1;
    end
    pend_nul = nul;
  endtask

  // Idle until every expected write is seen and the bus is quiet.
  task automatic drain();
    do
    begin
      @(negedge clk);
      i_op_valid = 1'b0;
      i_nullify  = pend_nul;
      pend_nul   = 1'b0;
      #1;                                             // Comparator has run for this edge.
    end
    while (exp_q.size() != 0 || o_apb.psel);
    repeat (2)
    begin
      @(negedge clk);
      i_nullify = 1'b0;
    end
  endtask

  // Comparator, one check per change of o_wb.
  always @(negedge clk)
  begin
    if (nrst && o_wb !== last_wb)
    begin
      last_wb = o_wb;
      if (o_wb.rd_no != 5'd0)
      begin
        checks++;
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("error at %0t: write to r%0d with no op pending", $time, o_wb.rd_no);
        end
        else
        begin
          if (o_wb !== exp_q[0])
          begin
            errors++;
            $display("error at %0t: wb r%0d=%h, expected r%0d=%h", $time, o_wb.rd_no,
                     o_wb.rd_val, exp_q[0].rd_no, exp_q[0].rd_val);
          end
          if (alu_q[0] && cycles != acc_q[0] + 2)
          begin
            errors++;
            $display("error at %0t: ALU result late by %0d cycles", $time,
                     cycles - acc_q[0] - 2);
          end
          void'(exp_q.pop_front());
          void'(acc_q.pop_front());
          void'(alu_q.pop_front());
        end
      end
    end
  end

  // APB protocol and writeback freeze during transfers.
  always @(negedge clk)
  begin
    if (nrst)
    begin
      if (p_valid && p_req.psel && !(p_req.penable && p_rdy) && o_wb !== p_wb)
      begin
        errors++;
        $display("error at %0t: o_wb changed during an APB transfer", $time);
      end
      if (p_valid && p_req.psel && !p_req.penable && !(o_apb.psel && o_apb.penable))
      begin
        errors++;
        $display("error at %0t: SETUP not followed by ACCESS", $time);
      end
      if (p_valid && p_req.penable && !p_rdy && o_apb !== p_req)
      begin
        errors++;
        $display("error at %0t: APB request changed before pready", $time);
      end
      if (o_apb.psel && !mem_seen)
      begin
        errors++;
        $display("error at %0t: psel before any memory operation", $time);
      end
      p_req   = o_apb;
      p_rdy   = apb_rsp.pready;
      p_wb    = o_wb;
      p_valid = 1'b1;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > 40 * issued + 100)
    begin
      $display("Timeout after %0d cycles with %0d ops issued", cycles, issued);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    int          st;
    int          e0;
    logic [31:0] w;
    logic [4:0]  rd;
    cpu_pkg::op_t opc;
    clk        = 1'b0;
    nrst       = 1'b0;
    i_op       = '0;
    i_op_valid = 1'b0;
    i_nullify  = 1'b0;
    lfsr_state = 32'h5bf19aa6;
    cycles     = 0;
    issued     = 0;
    errors     = 0;
    checks     = 0;
    pend_nul   = 1'b0;
    mem_seen   = 1'b0;
    last_rd    = 5'd0;
    last_wb    = '0;
    p_valid    = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      mregs[i] = '0;
    end
    for (int i = 0; i < 64; i++)
    begin
      mmem[i] = 32'h1f3d5b79 ^ (i * 32'h01000193);    // Same fill as the memory model.
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;

    // Reset state.
    @(negedge clk);
    checks++;
    if (o_wb !== '0 || o_op_ready !== 1'b1)
    begin
      errors++;
      $display("error at %0t: reset state wb=%h ready=%b", $time, o_wb, o_op_ready);
    end
    $display("test 1 reset: %0d errors", errors);

    // Random ALU ops on r1..r8.
    e0 = errors;
    for (int r = 1; r <= 8; r++)
    begin
      send(cpu_pkg::OP_ADDI, 5'(r), 5'd0, 5'd0, 16'(take_bits(16)), 1'b0, st);
    end
    for (int i = 0; i < 24; i++)
    begin
      w   = take_bits(3);
      opc = (w >= 6) ? cpu_pkg::OP_ADDI : cpu_pkg::op_t'(4'(w));
      rd  = pick_rd();
      send(opc, rd, 5'(take_bits(3)) + 5'd1, 5'(take_bits(3)) + 5'd1,
           16'(take_bits(16)), 1'b0, st);
    end
    drain();
    $display("test 2 random ALU: %0d errors", errors - e0);

    // Back-to-back dependency and r0.
    e0 = errors;
    send(cpu_pkg::OP_ADDI, 5'd3, 5'd1, 5'd0, 16'h0123, 1'b0, st);
    send(cpu_pkg::OP_ADD, 5'd4, 5'd3, 5'd3, 16'h0, 1'b0, st);
    checks++;
    if (st == 0)
    begin
      errors++;
      $display("error at %0t: dependent op was not held off", $time);
    end
    send(cpu_pkg::OP_ADDI, 5'd0, 5'd4, 5'd0, 16'h7fff, 1'b0, st);
    send(cpu_pkg::OP_OR, 5'd5, 5'd0, 5'd0, 16'h0, 1'b0, st);
    send(cpu_pkg::OP_ADD, 5'd6, 5'd0, 5'd4, 16'h0, 1'b0, st);
    drain();
    $display("test 3 dependency: %0d errors", errors - e0);

    // Stores then loads under random wait states.
    e0 = errors;
    for (int i = 0; i < 8; i++)
    begin
      w = take_bits(6);
      send(cpu_pkg::OP_ADDI, 5'd9, 5'd0, 5'd0, 16'(take_bits(16)), 1'b0, st);
      send(cpu_pkg::OP_SW, 5'd0, 5'd0, 5'd9, {8'h0, w[5:0], 2'b00}, 1'b0, st);
      send(cpu_pkg::OP_LW, (i % 2) ? 5'd10 : 5'd11, 5'd0, 5'd0, {8'h0, w[5:0], 2'b00},
           1'b0, st);
    end
    drain();
    $display("test 4 load/store: %0d errors", errors - e0);

    // Nullified ops leave registers and memory alone.
    e0 = errors;
    send(cpu_pkg::OP_ADDI, 5'd12, 5'd0, 5'd0, 16'h5a5a, 1'b1, st);
    send(cpu_pkg::OP_ADD, 5'd13, 5'd12, 5'd0, 16'h0, 1'b0, st);
    send(cpu_pkg::OP_ADDI, 5'd14, 5'd0, 5'd0, 16'h3c3c, 1'b0, st);
    send(cpu_pkg::OP_SW, 5'd0, 5'd0, 5'd14, 16'h0040, 1'b1, st);
    send(cpu_pkg::OP_LW, 5'd15, 5'd0, 5'd0, 16'h0040, 1'b1, st);
    send(cpu_pkg::OP_LW, 5'd16, 5'd0, 5'd0, 16'h0040, 1'b0, st);
    send(cpu_pkg::OP_OR, 5'd17, 5'd15, 5'd12, 16'h0, 1'b0, st);
    drain();
    $display("test 5 nullify: %0d errors", errors - e0);

    $display("%0d checks, %0d errors, %0d ops issued", checks, errors, issued);
    if (errors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/cpu_pkg.sv
design/regfile.sv
design/issue_ctl.sv
design/alu_unit.sv
mem_access/mem_access.sv
design/writeback.sv
design/cpu_backend.sv
verif/apb_mem_model.sv
verif/tb_cpu_backend.sv
